/* decode_stage.f */
src/decode_pkg.sv
src/ctrl_decoder.sv
src/imm_gen.sv
src/decode_stage.sv
testbench/decode_stage_checker.sv
testbench/decode_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f decode_stage.f \
        --top-module decode_stage_tb -o decode_stage_sim

./obj_dir/decode_stage_sim 2>&1 | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
        echo "Simulation failed"
        exit 1
fi
echo "Simulation passed"

/* src/ctrl_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module ctrl_decoder (
        input  logic [decode_pkg::XLEN-1:0]       instr_i,
        output logic [decode_pkg::REG_ADDR_W-1:0] rs1_o,
        output logic [decode_pkg::REG_ADDR_W-1:0] rs2_o,
        output logic [decode_pkg::REG_ADDR_W-1:0] rd_o,
        output decode_pkg::ctrl_t                 ctrl_o,
        output decode_pkg::imm_fmt_e              imm_fmt_o
);
        import decode_pkg::*;

        opcode_e    opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;

        ctrl_t      ctrl;
        imm_fmt_e   imm_fmt;
        logic       use_rs1;
        logic       use_rs2;
        logic       use_rd;
        logic       legal;

        assign opcode = opcode_e'(instr_i[6:0]);
        assign funct3 = instr_i[14:12];
        assign funct7 = instr_i[31:25];

        always_comb begin
                ctrl    = '0;
                imm_fmt = IMM_NONE;
                use_rs1 = 1'b0;
                use_rs2 = 1'b0;
                use_rd  = 1'b0;
                legal   = 1'b1;

                case (opcode)
                OPC_LUI: begin
                        ctrl.alu_op   = ALU_PASS;
                        ctrl.alu_src1 = SRC_IMM;
                        imm_fmt       = IMM_U;
                        use_rd        = 1'b1;
                end
                OPC_AUIPC: begin
                        ctrl.alu_op   = ALU_ADD;
                        ctrl.alu_src1 = SRC_IMM;
                        ctrl.alu_src2 = SRC_PC;
                        imm_fmt       = IMM_U;
                        use_rd        = 1'b1;
                end
                OPC_JAL: begin
                        ctrl.alu_op = ALU_PASS;
                        ctrl.branch = 1'b1; // Target known at decode
                        ctrl.jump   = 1'b1;
                        imm_fmt     = IMM_J;
                        use_rd      = 1'b1;
                end
                OPC_JALR: begin
                        ctrl.alu_op   = ALU_PASS;
                        ctrl.alu_src1 = SRC_PC;
                        ctrl.jump     = 1'b1;
                        imm_fmt       = IMM_I;
                        use_rs1       = 1'b1;
                        use_rd        = 1'b1;
                        legal         = (funct3 == F3_JALR);
                end
                OPC_BRANCH: begin
                        ctrl.alu_src1 = SRC_RS1;
                        ctrl.alu_src2 = SRC_RS2;
                        ctrl.branch   = 1'b1;
                        imm_fmt       = IMM_B;
                        use_rs1       = 1'b1;
                        use_rs2       = 1'b1;
                        case (funct3)
                        F3_BEQ:  ctrl.alu_op = ALU_EQ;
                        F3_BNE:  ctrl.alu_op = ALU_NE;
                        F3_BLT:  ctrl.alu_op = ALU_SLT;
                        F3_BGE:  ctrl.alu_op = ALU_SGE;
                        F3_BLTU: ctrl.alu_op = ALU_SLTU;
                        F3_BGEU: ctrl.alu_op = ALU_SGEU;
                        default: legal = 1'b0;
                        endcase
                end
                OPC_LOAD: begin
                        ctrl.alu_op   = ALU_ADD; // Address = rs1 + imm
                        ctrl.alu_src1 = SRC_RS1;
                        ctrl.alu_src2 = SRC_IMM;
                        ctrl.mem_re   = 1'b1;
                        imm_fmt       = IMM_I;
                        use_rs1       = 1'b1;
                        use_rd        = 1'b1;
                        case (funct3)
                        F3_LB:   ctrl.mem_size = BYTE_S;
                        F3_LBU:  ctrl.mem_size = BYTE_U;
                        F3_LH:   ctrl.mem_size = HALF_S;
                        F3_LHU:  ctrl.mem_size = HALF_U;
                        F3_LW:   ctrl.mem_size = WORD;
                        default: legal = 1'b0;
                        endcase
                end
                OPC_STORE: begin
                        ctrl.alu_op   = ALU_ADD;
                        ctrl.alu_src1 = SRC_RS1;
                        ctrl.alu_src2 = SRC_IMM;
                        ctrl.mem_we   = 1'b1;
                        imm_fmt       = IMM_S;
                        use_rs1       = 1'b1;
                        use_rs2       = 1'b1; // Store data
                        case (funct3)
                        F3_SB:   ctrl.mem_size = BYTE_U;
                        F3_SH:   ctrl.mem_size = HALF_U;
                        F3_SW:   ctrl.mem_size = WORD;
                        default: legal = 1'b0;
                        endcase
                end
                OPC_OP_IMM: begin
                        ctrl.alu_src1 = SRC_RS1;
                        ctrl.alu_src2 = SRC_IMM;
                        imm_fmt       = IMM_I;
                        use_rs1       = 1'b1;
                        use_rd        = 1'b1;
                        case (funct3)
                        F3_ADD:  ctrl.alu_op = ALU_ADD;
                        F3_SLT:  ctrl.alu_op = ALU_SLT;
                        F3_SLTU: ctrl.alu_op = ALU_SLTU;
                        F3_XOR:  ctrl.alu_op = ALU_XOR;
                        F3_OR:   ctrl.alu_op = ALU_OR;
                        F3_AND:  ctrl.alu_op = ALU_AND;
                        F3_SLL: begin
                                ctrl.alu_op = ALU_SLL;
                                imm_fmt     = IMM_SHAMT;
                                legal       = (funct7 == F7_NORMAL);
                        end
                        F3_SR: begin
                                imm_fmt = IMM_SHAMT;
                                if (funct7 == F7_ALT) begin
                                        ctrl.alu_op = ALU_SRA;
                                end else begin
                                        ctrl.alu_op = ALU_SRL;
                                        legal       = (funct7 == F7_NORMAL);
                                end
                        end
                        endcase
                end
                OPC_OP: begin
                        ctrl.alu_src1 = SRC_RS1;
                        ctrl.alu_src2 = SRC_RS2;
                        use_rs1       = 1'b1;
                        use_rs2       = 1'b1;
                        use_rd        = 1'b1;
                        case (funct3)
                        F3_ADD:  ctrl.alu_op = (funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                        F3_SR:   ctrl.alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                        F3_SLL:  ctrl.alu_op = ALU_SLL;
                        F3_SLT:  ctrl.alu_op = ALU_SLT;
                        F3_SLTU: ctrl.alu_op = ALU_SLTU;
                        F3_XOR:  ctrl.alu_op = ALU_XOR;
                        F3_OR:   ctrl.alu_op = ALU_OR;
                        F3_AND:  ctrl.alu_op = ALU_AND;
                        endcase
                        // Alternate funct7 only exists for SUB and SRA
                        legal = (funct7 == F7_NORMAL) ||
                                (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR));
                end
                default: legal = 1'b0;
                endcase

                if (!legal) begin
                        ctrl    = '0;
                        imm_fmt = IMM_NONE;
                        use_rs1 = 1'b0;
                        use_rs2 = 1'b0;
                        use_rd  = 1'b0;
                end
        end

        assign rs1_o     = use_rs1 ? instr_i[19:15] : '0;
        assign rs2_o     = use_rs2 ? instr_i[24:20] : '0;
        assign rd_o      = use_rd  ? instr_i[11:7]  : '0;
        assign ctrl_o    = ctrl;
        assign imm_fmt_o = imm_fmt;

endmodule

`default_nettype wire

/* src/decode_pkg.sv */
`default_nettype none

package decode_pkg;

        localparam int XLEN       = 32;
        localparam int REG_ADDR_W = 5;

        ////////////////////////////////////////////////////////////
        // Major opcodes

        typedef enum logic [6:0] {
                OPC_LUI    = 7'b0110111,
                OPC_AUIPC  = 7'b0010111,
                OPC_JAL    = 7'b1101111,
                OPC_JALR   = 7'b1100111,
                OPC_BRANCH = 7'b1100011,
                OPC_LOAD   = 7'b0000011,
                OPC_STORE  = 7'b0100011,
                OPC_OP_IMM = 7'b0010011,
                OPC_OP     = 7'b0110011
        } opcode_e;

        // funct3 per class
        localparam logic [2:0] F3_JALR = 3'b000;

        localparam logic [2:0] F3_BEQ  = 3'b000;
        localparam logic [2:0] F3_BNE  = 3'b001;
        localparam logic [2:0] F3_BLT  = 3'b100;
        localparam logic [2:0] F3_BGE  = 3'b101;
        localparam logic [2:0] F3_BLTU = 3'b110;
        localparam logic [2:0] F3_BGEU = 3'b111;

        localparam logic [2:0] F3_LB  = 3'b000;
        localparam logic [2:0] F3_LH  = 3'b001;
        localparam logic [2:0] F3_LW  = 3'b010;
        localparam logic [2:0] F3_LBU = 3'b100;
        localparam logic [2:0] F3_LHU = 3'b101;

        localparam logic [2:0] F3_SB = 3'b000;
        localparam logic [2:0] F3_SH = 3'b001;
        localparam logic [2:0] F3_SW = 3'b010;

        localparam logic [2:0] F3_ADD  = 3'b000; // Also SUB
        localparam logic [2:0] F3_SLL  = 3'b001;
        localparam logic [2:0] F3_SLT  = 3'b010;
        localparam logic [2:0] F3_SLTU = 3'b011;
        localparam logic [2:0] F3_XOR  = 3'b100;
        localparam logic [2:0] F3_SR   = 3'b101; // SRL or SRA
        localparam logic [2:0] F3_OR   = 3'b110;
        localparam logic [2:0] F3_AND  = 3'b111;

        localparam logic [6:0] F7_NORMAL = 7'b0000000;
        localparam logic [6:0] F7_ALT    = 7'b0100000; // SUB, SRA, SRAI

        ////////////////////////////////////////////////////////////
        // Control encodings

        typedef enum logic [3:0] {
                ALU_NOP, ALU_PASS, ALU_ADD, ALU_SUB,
                ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
                ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
                ALU_EQ, ALU_NE, ALU_SGE, ALU_SGEU
        } alu_op_e;

        typedef enum logic [2:0] {
                SRC_NONE, SRC_RS1, SRC_RS2, SRC_IMM, SRC_PC
        } alu_src_e;

        typedef enum logic [2:0] {
                SIZE_UNDEF, BYTE_S, BYTE_U, HALF_S, HALF_U, WORD
        } data_size_e;

        typedef enum logic [2:0] {
                IMM_NONE, IMM_I, IMM_SHAMT, IMM_S, IMM_B, IMM_U, IMM_J
        } imm_fmt_e;

        typedef struct packed {
                alu_op_e    alu_op;
                alu_src_e   alu_src1;
                alu_src_e   alu_src2;
                logic       mem_re;
                logic       mem_we;
                data_size_e mem_size;
                logic       branch;
                logic       jump;
        } ctrl_t;

        // All zero is a bubble
        typedef struct packed {
                logic [REG_ADDR_W-1:0] rd;
                ctrl_t                 ctrl;
                logic [XLEN-1:0]       imm;
        } decoded_t;

endpackage

`default_nettype wire

/* src/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
        input  logic                              clk,
        input  logic                              rst_n,
        input  logic [decode_pkg::XLEN-1:0]       instr_i,
        input  logic                              stall_i,
        output logic [decode_pkg::REG_ADDR_W-1:0] sel_rs1_o,
        output logic [decode_pkg::REG_ADDR_W-1:0] sel_rs2_o,
        output decode_pkg::decoded_t              decoded_o
);
        import decode_pkg::*;

        logic [REG_ADDR_W-1:0] rd;
        ctrl_t                 ctrl;
        imm_fmt_e              imm_fmt;
        logic [XLEN-1:0]       imm;
        decoded_t              decoded_d;

        ctrl_decoder u_ctrl_decoder (
                .instr_i   (instr_i),
                .rs1_o     (sel_rs1_o), // Register file read happens this cycle
                .rs2_o     (sel_rs2_o),
                .rd_o      (rd),
                .ctrl_o    (ctrl),
                .imm_fmt_o (imm_fmt)
        );

        imm_gen u_imm_gen (
                .instr_i   (instr_i),
                .imm_fmt_i (imm_fmt),
                .imm_o     (imm)
        );

        assign decoded_d.rd   = rd;
        assign decoded_d.ctrl = ctrl;
        assign decoded_d.imm  = imm;

        ////////////////////////////////////////////////////////////
        // ID/EX register

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        decoded_o <= '0; // Bubble
                end else if (!stall_i) begin
                        decoded_o <= decoded_d;
                end
        end

endmodule

`default_nettype wire

/* src/imm_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module imm_gen (
        input  logic [decode_pkg::XLEN-1:0] instr_i,
        input  decode_pkg::imm_fmt_e        imm_fmt_i,
        output logic [decode_pkg::XLEN-1:0] imm_o
);
        import decode_pkg::*;

        logic sign;

        assign sign = instr_i[31]; // Sign bit is always bit 31

        always_comb begin
                case (imm_fmt_i)
                IMM_I: imm_o = {{(XLEN-12){sign}}, instr_i[31:20]};
                IMM_SHAMT: imm_o = {{(XLEN-5){1'b0}}, instr_i[24:20]};
                IMM_S: imm_o = {{(XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};
                IMM_B: begin
                        imm_o = {{(XLEN-12){sign}}, instr_i[7], instr_i[30:25],
                                 instr_i[11:8], 1'b0};
                end
                IMM_U: imm_o = {instr_i[31:12], 12'd0};
                IMM_J: begin
                        imm_o = {{(XLEN-20){sign}}, instr_i[19:12], instr_i[20],
                                 instr_i[30:21], 1'b0};
                end
                default: imm_o = '0; // IMM_NONE
                endcase
        end

endmodule

`default_nettype wire

/* testbench/decode_stage_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage_checker (
        input logic                 clk,
        input logic                 rst_n,
        input logic                 stall_i,
        input decode_pkg::decoded_t decoded_o
);
        import decode_pkg::*;

        // Load and store are exclusive
        mem_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
                !(decoded_o.ctrl.mem_re && decoded_o.ctrl.mem_we))
                else $error("mem_re and mem_we both set");

        jump_no_mem: assert property (@(posedge clk) disable iff (!rst_n)
                decoded_o.ctrl.jump |-> !decoded_o.ctrl.mem_re && !decoded_o.ctrl.mem_we)
                else $error("jump with memory access");

        hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
                $past(stall_i) |-> $stable(decoded_o))
                else $error("decoded_o changed across a stalled edge");

        bubble_after_reset: assert property (@(posedge clk)
                $rose(rst_n) |-> decoded_o == '0)
                else $error("decoded_o not a bubble after reset");

endmodule

bind decode_stage decode_stage_checker u_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall_i   (stall_i),
        .decoded_o (decoded_o)
);

`default_nettype wire

/* testbench/decode_stage_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage_tb;
        import decode_pkg::*;

        typedef struct packed {
                logic [REG_ADDR_W-1:0] rs1;
                logic [REG_ADDR_W-1:0] rs2;
                decoded_t              d;
        } expect_t;

        localparam int N_DIRECTED  = 9 * 8 * 3;
        localparam int N_RANDOM    = 400;
        localparam int TEST_CYCLES = 2 + N_DIRECTED + N_RANDOM + 4;

        localparam logic [6:0] KEPT_OP [9] = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h63,
                                               7'h03, 7'h23, 7'h13, 7'h33};
        localparam logic [6:0] F7_SET [3] = '{7'h00, 7'h20, 7'h7f}; // 7f gives negative imm

        logic                  clk;
        logic                  rst_n;
        logic [XLEN-1:0]       instr_i;
        logic                  stall_i;
        logic [REG_ADDR_W-1:0] sel_rs1_o;
        logic [REG_ADDR_W-1:0] sel_rs2_o;
        decoded_t              decoded_o;
        decoded_t              exp_decoded;
        expect_t               exp_now;
        logic [31:0]           lcg_state;

        decode_stage u_dut (
                .clk       (clk),
                .rst_n     (rst_n),
                .instr_i   (instr_i),
                .stall_i   (stall_i),
                .sel_rs1_o (sel_rs1_o),
                .sel_rs2_o (sel_rs2_o),
                .decoded_o (decoded_o)
        );

        function automatic logic [31:0] lcg_next();
                lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
                return lcg_state;
        endfunction

        // Expected decode straight from the RV32I encoding rules
        function automatic expect_t ref_decode(input logic [31:0] w);
                expect_t    e;
                logic [2:0] f3;
                logic [6:0] f7;
                logic       ok;
                logic       r1;
                logic       r2;
                logic       rdu;
                e   = '0;
                f3  = w[14:12];
                f7  = w[31:25];
                ok  = 1'b1;
                r1  = 1'b1;
                r2  = 1'b0;
                rdu = 1'b1;
                case (w[6:0])
                7'h37, 7'h17: begin
                        e.d.ctrl.alu_op   = (w[5]) ? ALU_PASS : ALU_ADD;
                        e.d.ctrl.alu_src1 = SRC_IMM;
                        e.d.ctrl.alu_src2 = (w[5]) ? SRC_NONE : SRC_PC;
                        e.d.imm           = {w[31:12], 12'd0};
                        r1                = 1'b0;
                end
                7'h6f: begin
                        e.d.ctrl.alu_op = ALU_PASS;
                        e.d.ctrl.branch = 1'b1;
                        e.d.ctrl.jump   = 1'b1;
                        e.d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                        r1      = 1'b0;
                end
                7'h67: begin
                        ok                = (f3 == 3'd0);
                        e.d.ctrl.alu_op   = ALU_PASS;
                        e.d.ctrl.alu_src1 = SRC_PC;
                        e.d.ctrl.jump     = 1'b1;
                        e.d.imm           = {{20{w[31]}}, w[31:20]};
                end
                7'h63: begin
                        ok = (f3 != 3'd2) && (f3 != 3'd3);
                        case (f3)
                        3'd0: e.d.ctrl.alu_op = ALU_EQ;
                        3'd1: e.d.ctrl.alu_op = ALU_NE;
                        3'd4: e.d.ctrl.alu_op = ALU_SLT;
                        3'd5: e.d.ctrl.alu_op = ALU_SGE;
                        3'd6: e.d.ctrl.alu_op = ALU_SLTU;
                        default: e.d.ctrl.alu_op = ALU_SGEU;
                        endcase
                        e.d.ctrl.alu_src1 = SRC_RS1;
                        e.d.ctrl.alu_src2 = SRC_RS2;
                        e.d.ctrl.branch   = 1'b1;
                        e.d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                        r2      = 1'b1;
                        rdu     = 1'b0;
                end
                7'h03, 7'h23: begin
                        e.d.ctrl.alu_op   = ALU_ADD;
                        e.d.ctrl.alu_src1 = SRC_RS1;
                        e.d.ctrl.alu_src2 = SRC_IMM;
                        if (w[5]) begin // Store
                                ok              = (f3 < 3'd3);
                                e.d.ctrl.mem_we = 1'b1;
                                e.d.imm         = {{20{w[31]}}, w[31:25], w[11:7]};
                                r2              = 1'b1;
                                rdu             = 1'b0;
                                case (f3)
                                3'd0: e.d.ctrl.mem_size = BYTE_U;
                                3'd1: e.d.ctrl.mem_size = HALF_U;
                                default: e.d.ctrl.mem_size = WORD;
                                endcase
                        end else begin
                                ok              = (f3 != 3'd3) && (f3 < 3'd6);
                                e.d.ctrl.mem_re = 1'b1;
                                e.d.imm         = {{20{w[31]}}, w[31:20]};
                                case (f3)
                                3'd0: e.d.ctrl.mem_size = BYTE_S;
                                3'd1: e.d.ctrl.mem_size = HALF_S;
                                3'd4: e.d.ctrl.mem_size = BYTE_U;
                                3'd5: e.d.ctrl.mem_size = HALF_U;
                                default: e.d.ctrl.mem_size = WORD;
                                endcase
                        end
                end
                7'h13, 7'h33: begin
                        e.d.ctrl.alu_src1 = SRC_RS1;
                        e.d.ctrl.alu_src2 = (w[5]) ? SRC_RS2 : SRC_IMM;
                        case (f3)
                        3'd0: e.d.ctrl.alu_op = (w[5] && f7 == 7'h20) ? ALU_SUB : ALU_ADD;
                        3'd1: e.d.ctrl.alu_op = ALU_SLL;
                        3'd2: e.d.ctrl.alu_op = ALU_SLT;
                        3'd3: e.d.ctrl.alu_op = ALU_SLTU;
                        3'd4: e.d.ctrl.alu_op = ALU_XOR;
                        3'd5: e.d.ctrl.alu_op = (f7 == 7'h20) ? ALU_SRA : ALU_SRL;
                        3'd6: e.d.ctrl.alu_op = ALU_OR;
                        default: e.d.ctrl.alu_op = ALU_AND;
                        endcase
                        if (w[5]) begin // R-type
                                ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                                r2 = 1'b1;
                        end else if (f3 == 3'd1 || f3 == 3'd5) begin
                                ok      = (f7 == 7'h00) || (f7 == 7'h20 && f3 == 3'd5);
                                e.d.imm = {27'd0, w[24:20]};
                        end else begin
                                e.d.imm = {{20{w[31]}}, w[31:20]};
                        end
                end
                default: ok = 1'b0;
                endcase
                if (!ok) begin
                        e = '0;
                end else begin
                        e.rs1  = r1  ? w[19:15] : '0;
                        e.rs2  = r2  ? w[24:20] : '0;
                        e.d.rd = rdu ? w[11:7]  : '0;
                end
                return e;
        endfunction

        task automatic report_error(input string msg);
                $display("[ERROR] %0t ns: %s", $time, msg);
                $display("=== FAIL ===");
                $fatal(1);
        endtask

        task automatic drive_directed();
                logic [31:0] w;
                for (int o = 0; o < 9; o++) begin
                        for (int f3 = 0; f3 < 8; f3++) begin
                                for (int k = 0; k < 3; k++) begin
                                        w          = lcg_next();
                                        w[6:0]     = KEPT_OP[o];
                                        w[14:12]   = 3'(f3);
                                        w[31:25]   = F7_SET[k];
                                        @(posedge clk);
                                        instr_i <= w;
                                        stall_i <= 1'b0;
                                end
                        end
                end
        endtask

        task automatic drive_random(input int n);
                logic [31:0] r;
                logic [31:0] w;
                repeat (n) begin
                        r = lcg_next();
                        w = lcg_next();
                        if (r[0]) w[6:0] = KEPT_OP[int'(r[4:1]) % 9];
                        if (r[5]) w[31:25] = r[6] ? 7'h20 : 7'h00;
                        @(posedge clk);
                        instr_i <= w;
                        stall_i <= (r[10:8] == 3'd0) || (r[10:8] == 3'd1 && stall_i);
                end
        endtask

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        assign exp_now = ref_decode(instr_i);

        // Expectation advances only on unstalled edges
        always @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        exp_decoded <= '0;
                end else if (!stall_i) begin
                        exp_decoded <= exp_now.d;
                end
        end

        always @(negedge clk) begin
                if (rst_n) begin
                        assert (sel_rs1_o == exp_now.rs1)
                        else report_error($sformatf("sel_rs1_o %0d for %h", sel_rs1_o, instr_i));
                        assert (sel_rs2_o == exp_now.rs2)
                        else report_error($sformatf("sel_rs2_o %0d for %h", sel_rs2_o, instr_i));
                        assert (decoded_o == exp_decoded)
                        else report_error($sformatf("decoded_o %h, expected %h",
                                                    decoded_o, exp_decoded));
                end
        end

        initial begin
                #((TEST_CYCLES + 100) * 10);
                $display("Timeout: the test did not finish in time");
                $display("=== FAIL ===");
                $fatal(1);
        end

        initial begin
                lcg_state   = 32'hcb84;
                rst_n       = 1'b0;
                instr_i     = '0;
                stall_i     = 1'b0;
                repeat (2) @(posedge clk);
                rst_n <= 1'b1;
                drive_directed();
                drive_random(N_RANDOM);
                @(posedge clk);
                stall_i <= 1'b0;
                repeat (2) @(posedge clk);
                $display("=== PASS ===");
                $finish;
        end

endmodule

`default_nettype wire
